// File: hw/ref_subst_pkg.sv
package ref_subst_pkg;

	// field widths
	localparam int BANK_ADR_W = 3;
	localparam int POS4_W = 5;
	localparam int BP_POS_W = POS4_W + 1;
	localparam int AWK_CNT_W = 3;
	localparam int ORDER_W = 3;
	localparam int Y_IN_CU_W = 7;

	// geometry of one neighbour line
	localparam int N_BANKS = 8;
	localparam int SAMPLES_PER_BANK = 4;
	localparam int LINE_SAMPLES = N_BANKS * SAMPLES_PER_BANK; // 32 samples per line

	// bank pseudo address, bit 0 set marks a left neighbour
	typedef logic [BANK_ADR_W-1:0] bank_adr_t;

	// position along the neighbour line in units of 4 samples
	typedef logic [POS4_W-1:0] pos4_t;

	// pending bypass location: {side, pos4}
	typedef logic [BP_POS_W-1:0] bp_pos_t;

	// cycles since the transform block started
	typedef logic [AWK_CNT_W-1:0] awk_cnt_t;

	// transform block index within its group
	typedef logic [ORDER_W-1:0] order_t;

	// vertical offset of the TB inside the CU
	typedef logic [Y_IN_CU_W-1:0] y_in_cu_t;

	// side flag position inside bp_pos_t
	localparam int BP_SIDE_BIT = POS4_W;

	// all-ones address, bank carries nothing (7)
	localparam bank_adr_t ADR_INVALID = '1;

	// awake counter must exceed these before a bypass entry is trusted
	localparam awk_cnt_t BP2_MIN_AWK = 3'd2;
	localparam awk_cnt_t BP3_MIN_AWK = 3'd2;

endpackage

// File: hw/ref_subst_lane.sv
`timescale 1ns/1ps
module ref_subst_lane #(
	parameter int bit_depth = 8
) (
	input logic clk,
	input logic arst_n,
	input logic stall,

	input logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] bank_data,
	input ref_subst_pkg::bank_adr_t bank_adr,
	input ref_subst_pkg::pos4_t bank_pos,

	input logic is_above,
	input logic is_left,
	input logic is_top_left,

	input logic is_bt_border,
	input logic is_rt_border,
	input ref_subst_pkg::pos4_t bt_border_pos,
	input ref_subst_pkg::pos4_t rt_border_pos,

	input ref_subst_pkg::y_in_cu_t y_in_cu,

	input logic [bit_depth-1:0] fill_l,
	input logic [bit_depth-1:0] fill_t,
	input logic [bit_depth-1:0] fill_b,
	input logic [bit_depth-1:0] fill_rt,

	input logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] bp2_samples,
	input ref_subst_pkg::bp_pos_t bp2_pos,
	input logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] bp3_samples,
	input ref_subst_pkg::bp_pos_t bp3_pos,
	input ref_subst_pkg::awk_cnt_t awk_cnt,

	output logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] sub_bank
);

	import ref_subst_pkg::*;

	localparam int BANK_W = SAMPLES_PER_BANK * bit_depth;
	localparam logic [bit_depth-1:0] HALF_VAL = {1'b1, {(bit_depth-1){1'b0}}};

	// bank classification
	logic adr_invalid;
	logic is_top_bank;
	logic is_left_bank;
	logic none_avail;
	logic top_veto;

	// bypass hits
	logic bp3_hit;
	logic bp2_hit;

	// substitution rule flags, highest priority first
	logic sel_half;
	logic sel_bp3;
	logic sel_bp2;
	logic sel_fill_t;
	logic sel_fill_l;
	logic sel_fill_b;
	logic sel_fill_rt;

	logic [BANK_W-1:0] sub_next;

	// one bypass entry against this bank
	function automatic logic bp_match(
		input bp_pos_t pos,
		input awk_cnt_t min_awk,
		input logic side,
		input pos4_t at,
		input awk_cnt_t cnt,
		input logic veto
	);
		logic side_ok;
		logic pos_ok;
		logic awake_ok;
		side_ok = (pos[BP_SIDE_BIT] == side);
		pos_ok = (pos[POS4_W-1:0] == at);
		awake_ok = (cnt > min_awk); // strictly past the minimum
		return side_ok && pos_ok && awake_ok && !veto;
	endfunction

	assign adr_invalid = (bank_adr == ADR_INVALID);
	assign is_top_bank = ~bank_adr[0];
	assign is_left_bank = bank_adr[0] && !adr_invalid;
	assign none_avail = !is_above && !is_left && !is_top_left;

	// top of the coding block reads the line buffer directly
	assign top_veto = is_top_bank && (y_in_cu == '0);

	assign bp3_hit = bp_match(bp3_pos, BP3_MIN_AWK, bank_adr[0], bank_pos, awk_cnt, top_veto);
	assign bp2_hit = bp_match(bp2_pos, BP2_MIN_AWK, bank_adr[0], bank_pos, awk_cnt, top_veto);

	assign sel_half = adr_invalid || none_avail;
	assign sel_bp3 = bp3_hit;
	assign sel_bp2 = bp2_hit;
	assign sel_fill_t = is_top_bank && !is_above && !is_top_left && is_left; // left only
	assign sel_fill_l = is_left_bank && !is_left && !is_top_left;

	// picture border, banks at or past the border position
	assign sel_fill_b = is_left_bank && is_bt_border && is_left && (bank_pos >= bt_border_pos);
	assign sel_fill_rt = is_top_bank && is_rt_border && is_above && (bank_pos >= rt_border_pos);

	always_comb begin
		if (sel_half)
			sub_next = {SAMPLES_PER_BANK{HALF_VAL}}; // mid-grey
		else if (sel_bp3)
			sub_next = bp3_samples;
		else if (sel_bp2)
			sub_next = bp2_samples;
		else if (sel_fill_t)
			sub_next = {SAMPLES_PER_BANK{fill_t}};
		else if (sel_fill_l)
			sub_next = {SAMPLES_PER_BANK{fill_l}};
		else if (sel_fill_b)
			sub_next = {SAMPLES_PER_BANK{fill_b}};
		else if (sel_fill_rt)
			sub_next = {SAMPLES_PER_BANK{fill_rt}};
		else
			sub_next = bank_data; // neighbour is usable as read
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sub_bank <= '0;
		else if (!stall)
			sub_bank <= sub_next;
	end

	// frozen output while the consumer stalls
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> $stable(sub_bank));

	// address drives every rule, an X here poisons the whole bank
	a_adr_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(bank_adr));

endmodule

// File: hw/ref_tl_select.sv
`timescale 1ns/1ps
module ref_tl_select #(
	parameter int bit_depth = 8
) (
	input logic clk,
	input logic arst_n,
	input logic stall,

	input logic is_above,
	input logic is_left,
	input logic is_top_left,

	input ref_subst_pkg::order_t order,

	input logic [bit_depth-1:0] data_tl,
	input logic [bit_depth-1:0] fill_l,
	input logic [bit_depth-1:0] fill_t,

	output logic [bit_depth-1:0] sub_tl
);

	localparam logic [bit_depth-1:0] HALF_VAL = {1'b1, {(bit_depth-1){1'b0}}};

	logic order_first;
	logic [bit_depth-1:0] tl_store; // corner fetched with the first TB
	logic [bit_depth-1:0] tl_next;

	assign order_first = (order == '0);

	always_comb begin
		if (!is_above && !is_left && !is_top_left)
			tl_next = HALF_VAL;
		else if (!is_above && !is_top_left)
			tl_next = fill_t;
		else if (!is_left && !is_top_left)
			tl_next = fill_l;
		else if (!is_top_left)
			tl_next = fill_t;
		else if (order_first)
			tl_next = data_tl; // fresh corner from the line buffer
		else
			tl_next = tl_store;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tl_store <= '0;
			sub_tl <= '0;
		end else if (!stall) begin
			sub_tl <= tl_next;
			if (order_first)
				tl_store <= data_tl;
		end
	end

	// later TBs of the group must see the corner captured on order 0
	a_store_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(order != '0) |=> $stable(tl_store));

endmodule

// File: hw/ref_subst_top.sv
`timescale 1ns/1ps
module ref_subst_top #(
	parameter int bit_depth = 8
) (
	input logic clk,
	input logic arst_n,
	input logic stall,

	// neighbour line, bank 0 and sample 0 in the top bits
	input logic [ref_subst_pkg::LINE_SAMPLES*bit_depth-1:0] data,
	input logic [ref_subst_pkg::N_BANKS*ref_subst_pkg::BANK_ADR_W-1:0] bank_adr,
	input logic [ref_subst_pkg::N_BANKS*ref_subst_pkg::POS4_W-1:0] bank_pos,

	input logic is_above,
	input logic is_left,
	input logic is_top_left,

	input logic is_bt_border,
	input logic is_rt_border,
	input ref_subst_pkg::pos4_t bt_border_pos,
	input ref_subst_pkg::pos4_t rt_border_pos,

	input ref_subst_pkg::y_in_cu_t y_in_cu,
	input ref_subst_pkg::order_t order,

	input logic [bit_depth-1:0] fill_l,
	input logic [bit_depth-1:0] fill_t,
	input logic [bit_depth-1:0] fill_b,
	input logic [bit_depth-1:0] fill_rt,
	input logic [bit_depth-1:0] data_tl,

	input logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] bp2_samples,
	input ref_subst_pkg::bp_pos_t bp2_pos,
	input logic [ref_subst_pkg::SAMPLES_PER_BANK*bit_depth-1:0] bp3_samples,
	input ref_subst_pkg::bp_pos_t bp3_pos,
	input ref_subst_pkg::awk_cnt_t awk_cnt,

	output logic [ref_subst_pkg::LINE_SAMPLES*bit_depth-1:0] sub_data,
	output logic [bit_depth-1:0] sub_tl
);

	import ref_subst_pkg::*;

	localparam int BANK_W = SAMPLES_PER_BANK * bit_depth;

	// one lane per bank, bank 0 sits in the top slice
	for (genvar i = 0; i < N_BANKS; i++) begin : g_lane
		ref_subst_lane #(
			.bit_depth(bit_depth)
		) i_lane (
			.clk(clk),
			.arst_n(arst_n),
			.stall(stall),
			.bank_data(data[(N_BANKS-1-i)*BANK_W +: BANK_W]),
			.bank_adr(bank_adr[(N_BANKS-1-i)*BANK_ADR_W +: BANK_ADR_W]),
			.bank_pos(bank_pos[(N_BANKS-1-i)*POS4_W +: POS4_W]),
			.is_above(is_above),
			.is_left(is_left),
			.is_top_left(is_top_left),
			.is_bt_border(is_bt_border),
			.is_rt_border(is_rt_border),
			.bt_border_pos(bt_border_pos),
			.rt_border_pos(rt_border_pos),
			.y_in_cu(y_in_cu),
			.fill_l(fill_l),
			.fill_t(fill_t),
			.fill_b(fill_b),
			.fill_rt(fill_rt),
			.bp2_samples(bp2_samples),
			.bp2_pos(bp2_pos),
			.bp3_samples(bp3_samples),
			.bp3_pos(bp3_pos),
			.awk_cnt(awk_cnt),
			.sub_bank(sub_data[(N_BANKS-1-i)*BANK_W +: BANK_W])
		);
	end

	// corner sample, shared by the whole line
	ref_tl_select #(
		.bit_depth(bit_depth)
	) i_tl_select (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.is_above(is_above),
		.is_left(is_left),
		.is_top_left(is_top_left),
		.order(order),
		.data_tl(data_tl),
		.fill_l(fill_l),
		.fill_t(fill_t),
		.sub_tl(sub_tl)
	);

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps
module tb_clkgen #(
	parameter real period_ns = 10.0,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1; // released on an edge, flops leave reset one cycle later
	end

endmodule

// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

	// corner the model captured on the last unstalled order 0
	logic [SAMPLE_W-1:0] model_tl_store;

	function automatic logic [SAMPLE_W-1:0] half_value();
		logic [SAMPLE_W-1:0] half;
		half = '0;
		half[SAMPLE_W-1] = 1'b1; // 2**(bit depth - 1)
		return half;
	endfunction

	// expected 4 samples of one bank, first matching rule wins
	function automatic logic [BANK_W-1:0] expected_bank(
		input logic [BANK_W-1:0] raw,
		input bank_adr_t adr,
		input pos4_t pos,
		input logic above, left, top_left,
		input logic bt_border, rt_border,
		input pos4_t bt_pos, rt_pos,
		input y_in_cu_t y_off,
		input logic [SAMPLE_W-1:0] f_l, f_t, f_b, f_rt,
		input logic [BANK_W-1:0] bp2_s, bp3_s,
		input bp_pos_t bp2_p, bp3_p,
		input awk_cnt_t awk
	);
		logic top_bank;
		logic left_bank;
		logic veto;
		logic hit2;
		logic hit3;
		top_bank = (adr[0] == 1'b0);
		left_bank = (adr[0] == 1'b1) && (adr != ADR_INVALID);
		veto = top_bank && (y_off == 0); // top of the coding block
		hit3 = (bp3_p == {adr[0], pos}) && (awk > BP3_MIN_AWK) && !veto;
		hit2 = (bp2_p == {adr[0], pos}) && (awk > BP2_MIN_AWK) && !veto;
		if ((adr == ADR_INVALID) || (!above && !left && !top_left))
			return {SAMPLES_PER_BANK{half_value()}};
		if (hit3)
			return bp3_s;
		if (hit2)
			return bp2_s;
		if (top_bank && !above && !top_left && left)
			return {SAMPLES_PER_BANK{f_t}};
		if (left_bank && !left && !top_left)
			return {SAMPLES_PER_BANK{f_l}};
		if (left_bank && bt_border && left && (pos >= bt_pos))
			return {SAMPLES_PER_BANK{f_b}};
		if (top_bank && rt_border && above && (pos >= rt_pos))
			return {SAMPLES_PER_BANK{f_rt}};
		return raw;
	endfunction

	// expected corner, also advances the model's stored corner
	function automatic logic [SAMPLE_W-1:0] expected_corner(
		input logic above, left, top_left,
		input order_t ord,
		input logic stalled,
		input logic [SAMPLE_W-1:0] d_tl, f_l, f_t
	);
		logic [SAMPLE_W-1:0] corner;
		if (!above && !left && !top_left)
			corner = half_value();
		else if (!above && !top_left)
			corner = f_t;
		else if (!left && !top_left)
			corner = f_l;
		else if (!top_left)
			corner = f_t;
		else if (ord == 0)
			corner = d_tl;
		else
			corner = model_tl_store;
		if (!stalled && (ord == 0))
			model_tl_store = d_tl;
		return corner;
	endfunction

`endif

// File: bench/tb_ref_subst.sv
`timescale 1ns/1ps
module tb_ref_subst;

	import ref_subst_pkg::*;

	localparam int SAMPLE_W = 8;
	localparam int BANK_W = SAMPLES_PER_BANK * SAMPLE_W;
	localparam int LINE_W = LINE_SAMPLES * SAMPLE_W;
	localparam int N_DIRECTED = 138;
	localparam int N_RANDOM = 2000;
	localparam int TIMEOUT_CYCLES = N_DIRECTED + N_RANDOM + 862; // reset, drain and margin

	logic clk;
	logic arst_n;
	logic stall;
	logic [LINE_W-1:0] data;
	logic [N_BANKS*BANK_ADR_W-1:0] bank_adr;
	logic [N_BANKS*POS4_W-1:0] bank_pos;
	logic is_above, is_left, is_top_left;
	logic is_bt_border, is_rt_border;
	pos4_t bt_border_pos, rt_border_pos;
	y_in_cu_t y_in_cu;
	order_t order;
	logic [SAMPLE_W-1:0] fill_l, fill_t, fill_b, fill_rt, data_tl;
	logic [BANK_W-1:0] bp2_samples, bp3_samples;
	bp_pos_t bp2_pos, bp3_pos;
	awk_cnt_t awk_cnt;
	logic [LINE_W-1:0] sub_data;
	logic [SAMPLE_W-1:0] sub_tl;

	integer seed = 32'hd4ae;
	int cycle_cnt = 0;
	int n_checks = 0;
	logic [LINE_W-1:0] exp_data_q[$];
	logic [SAMPLE_W-1:0] exp_tl_q[$];
	logic [LINE_W-1:0] last_data;
	logic [SAMPLE_W-1:0] last_tl;

	`include "tb_ref_model.svh"

	tb_clkgen #(.period_ns(10.0), .reset_cycles(4)) i_clkgen (.clk(clk), .arst_n(arst_n));

	ref_subst_top #(.bit_depth(SAMPLE_W)) i_dut (
		.clk(clk), .arst_n(arst_n), .stall(stall),
		.data(data), .bank_adr(bank_adr), .bank_pos(bank_pos),
		.is_above(is_above), .is_left(is_left), .is_top_left(is_top_left),
		.is_bt_border(is_bt_border), .is_rt_border(is_rt_border),
		.bt_border_pos(bt_border_pos), .rt_border_pos(rt_border_pos),
		.y_in_cu(y_in_cu), .order(order),
		.fill_l(fill_l), .fill_t(fill_t), .fill_b(fill_b), .fill_rt(fill_rt),
		.data_tl(data_tl),
		.bp2_samples(bp2_samples), .bp2_pos(bp2_pos),
		.bp3_samples(bp3_samples), .bp3_pos(bp3_pos), .awk_cnt(awk_cnt),
		.sub_data(sub_data), .sub_tl(sub_tl)
	);

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// whole line expectation, bank 0 in the top slice
	function automatic logic [LINE_W-1:0] expected_line();
		logic [LINE_W-1:0] line;
		for (int b = 0; b < N_BANKS; b++) begin
			line[(N_BANKS-1-b)*BANK_W +: BANK_W] = expected_bank(
				data[(N_BANKS-1-b)*BANK_W +: BANK_W],
				bank_adr[(N_BANKS-1-b)*BANK_ADR_W +: BANK_ADR_W],
				bank_pos[(N_BANKS-1-b)*POS4_W +: POS4_W],
				is_above, is_left, is_top_left, is_bt_border, is_rt_border,
				bt_border_pos, rt_border_pos, y_in_cu,
				fill_l, fill_t, fill_b, fill_rt,
				bp2_samples, bp3_samples, bp2_pos, bp3_pos, awk_cnt);
		end
		return line;
	endfunction

	// every field random, directed tasks override some of them afterwards
	task automatic drive_random(input logic allow_stall);
		logic [LINE_W-1:0] line;
		logic [N_BANKS*BANK_ADR_W-1:0] adrs;
		logic [N_BANKS*POS4_W-1:0] poss;
		for (int b = 0; b < N_BANKS; b++) begin
			line[(N_BANKS-1-b)*BANK_W +: BANK_W] = $random(seed);
			adrs[(N_BANKS-1-b)*BANK_ADR_W +: BANK_ADR_W] = 3'($random(seed));
			poss[(N_BANKS-1-b)*POS4_W +: POS4_W] = {2'b00, 3'($random(seed))}; // narrow, more hits
		end
		data <= line;
		bank_adr <= adrs;
		bank_pos <= poss;
		stall <= allow_stall && (3'($random(seed)) == 3'd0);
		is_above <= (2'($random(seed)) != 2'd0);
		is_left <= (2'($random(seed)) != 2'd0);
		is_top_left <= (2'($random(seed)) != 2'd0);
		is_bt_border <= 1'($random(seed));
		is_rt_border <= 1'($random(seed));
		bt_border_pos <= {2'b00, 3'($random(seed))};
		rt_border_pos <= {2'b00, 3'($random(seed))};
		y_in_cu <= (2'($random(seed)) == 2'd0) ? '0 : 7'($random(seed));
		order <= (2'($random(seed)) == 2'd0) ? '0 : 3'($random(seed));
		fill_l <= SAMPLE_W'($random(seed));
		fill_t <= SAMPLE_W'($random(seed));
		fill_b <= SAMPLE_W'($random(seed));
		fill_rt <= SAMPLE_W'($random(seed));
		data_tl <= SAMPLE_W'($random(seed));
		bp2_samples <= $random(seed);
		bp3_samples <= $random(seed);
		bp2_pos <= {1'($random(seed)), 2'b00, 3'($random(seed))};
		bp3_pos <= {1'($random(seed)), 2'b00, 3'($random(seed))};
		awk_cnt <= 3'($random(seed));
	endtask

	task automatic set_avail(input logic above, input logic left, input logic top_left);
		is_above <= above;
		is_left <= left;
		is_top_left <= top_left;
		is_bt_border <= 1'b0;
		is_rt_border <= 1'b0;
		awk_cnt <= '0; // no bypass entry trusted
	endtask

	// banks alternate top and left, positions count up from 0
	task automatic set_plain_banks(input logic with_invalid);
		logic [N_BANKS*BANK_ADR_W-1:0] adrs;
		logic [N_BANKS*POS4_W-1:0] poss;
		for (int b = 0; b < N_BANKS; b++) begin
			adrs[(N_BANKS-1-b)*BANK_ADR_W +: BANK_ADR_W] = (with_invalid && b % 3 == 0) ?
				ADR_INVALID : 3'(b % 6);
			poss[(N_BANKS-1-b)*POS4_W +: POS4_W] = POS4_W'(b);
		end
		bank_adr <= adrs;
		bank_pos <= poss;
	endtask

	task automatic run_directed();
		repeat (20) begin // pass-through, back to back
			@(posedge clk);
			drive_random(1'b0);
			set_avail(1'b1, 1'b1, 1'b1);
			set_plain_banks(1'b0);
		end
		for (int i = 0; i < 16; i++) begin // nothing available, then invalid banks
			@(posedge clk);
			drive_random(1'b0);
			set_avail(i >= 8, i >= 8, i >= 8);
			set_plain_banks(i >= 8);
		end
		for (int i = 0; i < 32; i++) begin // edge fill, then border fill
			@(posedge clk);
			drive_random(1'b0);
			set_plain_banks(1'b0);
			if (i < 8)
				set_avail(1'b0, 1'b1, 1'b0);
			else if (i < 16)
				set_avail(1'b1, 1'b0, 1'b0);
			else begin
				set_avail(1'b1, 1'b1, 1'b1);
				is_bt_border <= 1'b1;
				is_rt_border <= 1'b1;
			end
		end
		for (int i = 0; i < 32; i++) begin // bypass sweep over awk_cnt and y_in_cu
			@(posedge clk);
			drive_random(1'b0);
			set_avail(1'b1, 1'b1, 1'b1);
			set_plain_banks(1'b0);
			awk_cnt <= 3'(i % 8);
			y_in_cu <= (i % 16 < 8) ? 7'd0 : 7'd5;
			bp3_pos <= (i < 16) ? {1'b1, 5'd3} : {1'b0, 5'd2}; // bank 3 left, bank 2 top
			bp2_pos <= (i < 16) ? {1'b1, 5'd3} : {1'b0, 5'd4};
		end
		for (int i = 0; i < 32; i++) begin // corner: order runs, then availability
			@(posedge clk);
			drive_random(1'b0);
			set_avail(1'b1, 1'b1, 1'b1);
			order <= 3'(i % 4);
			if (i >= 16)
				set_avail(i[0], i[1], i[2]);
		end
		for (int i = 0; i < 6; i++) begin // stored corner frozen by stall
			@(posedge clk);
			drive_random(1'b0);
			set_avail(1'b1, 1'b1, 1'b1);
			order <= (i < 4) ? 3'd0 : 3'd2;
			stall <= (i >= 1 && i <= 3);
		end
	endtask

	initial begin
		stall <= 1'b0;
		drive_random(1'b0);
		wait (arst_n === 1'b1);
		run_directed();
		repeat (N_RANDOM) begin
			@(posedge clk);
			drive_random(1'b1);
		end
		@(posedge clk);
		stall <= 1'b0;
		repeat (3) @(posedge clk);
		if (n_checks > 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_on_failure("no DUT output was ever compared");
		end
	end

	// outputs checked mid-cycle, one edge after their inputs were captured
	always @(negedge clk) begin : compare
		logic [LINE_W-1:0] want_data;
		logic [SAMPLE_W-1:0] want_tl;
		if (!arst_n) begin
			exp_data_q.delete();
			exp_tl_q.delete();
			model_tl_store = '0;
			last_data = '0;
			last_tl = '0;
		end else begin
			if (exp_data_q.size() > 0) begin
				want_data = exp_data_q.pop_front();
				want_tl = exp_tl_q.pop_front();
				n_checks++;
				assert (sub_data === want_data) else
					stop_on_failure($sformatf("ERROR at %0t: sub_data %h, expected %h",
						$time, sub_data, want_data));
				assert (sub_tl === want_tl) else
					stop_on_failure($sformatf("ERROR at %0t: sub_tl %h, expected %h",
						$time, sub_tl, want_tl));
			end
			// model corner store only moves on an unstalled order 0
			want_tl = expected_corner(is_above, is_left, is_top_left, order, stall,
				data_tl, fill_l, fill_t);
			if (stall) begin
				want_data = last_data; // registers hold
				want_tl = last_tl;
			end else begin
				want_data = expected_line();
			end
			exp_data_q.push_back(want_data);
			exp_tl_q.push_back(want_tl);
			last_data = want_data;
			last_tl = want_tl;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_on_failure($sformatf("timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

endmodule

// File: sources.f
+incdir+bench
hw/ref_subst_pkg.sv
hw/ref_subst_lane.sv
hw/ref_tl_select.sv
hw/ref_subst_top.sv
bench/tb_clkgen.sv
bench/tb_ref_subst.sv
